// ==== list.f ====
verilog/memoryGamePkg.sv
verilog/buttonDebouncer.sv
verilog/cursorControl.sv
verilog/turnTimer.sv
verilog/gameBoard.sv
verilog/scoreDisplay.sv
verilog/memoryGameTop.sv
tests/clockGen.sv
tests/memoryGameTb.sv

// ==== Bender.yml ====
package:
  name: memory_game

sources:
  - verilog/memoryGamePkg.sv
  - verilog/buttonDebouncer.sv
  - verilog/cursorControl.sv
  - verilog/turnTimer.sv
  - verilog/gameBoard.sv
  - verilog/scoreDisplay.sv
  - verilog/memoryGameTop.sv
  - target: test
    files:
      - tests/clockGen.sv
      - tests/memoryGameTb.sv

// ==== tests/memoryGameTb.sv ====
`timescale 1ns/1ps

module memoryGameTb;

	localparam int DebounceCycles = 8;
	// one turn has to hold the eight moves between the two cards of a pair.
	localparam int CyclesPerSecond = 200;
	localparam int TurnSeconds = 3;
	localparam int IdleLimit = (TurnSeconds + 1) * CyclesPerSecond;

	logic clk50MHz;
	logic rstN;
	logic btnMove;
	logic btnSelect;
	memoryGamePkg::cellPos_t cursor;
	logic [15:0] shownMask;
	logic playerLed;
	logic gameOverLed;
	logic [6:0] secondsTens;
	logic [6:0] secondsUnits;
	logic [6:0] scoreOneSeg;
	logic [6:0] scoreTwoSeg;

	logic [31:0] seed;
	logic [3:0] modelCursor;
	logic [15:0] modelShown;
	logic [15:0] modelMatched;
	logic [3:0] modelFirst;
	logic modelFirstValid;
	logic modelPlayer;
	logic [3:0] modelScore [2];
	logic modelWaiting;
	logic modelGameOver;
	logic modelArmed;
	int testErrors;
	int passCount;
	int failCount;

	clockGen i_clockGen (
		.clk50MHz(clk50MHz),
		.rstN(rstN)
	);

	memoryGameTop #(
		.DebounceCycles(DebounceCycles),
		.CyclesPerSecond(CyclesPerSecond),
		.TurnSeconds(TurnSeconds)
	) i_memoryGameTop (.*);

	function automatic logic [31:0] nextRandom();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// reads a digit back from its segment pattern, -1 when the pattern is no digit.
	function automatic int digitOf(input logic [6:0] segments);
		int d;
		int found;
		found = -1;
		for (d = 0; d < 10; d++) begin
			if (memoryGamePkg::segmentsOf(4'(d)) === segments) begin
				found = d;
			end
		end
		return found;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAIL %0t %s: got %h, expected %h", $time, name, actual, expected);
			testErrors++;
		end
	endtask

	task automatic checkBoard();
		checkValue("cursor", cursor, modelCursor);
		checkValue("shownMask", shownMask, modelShown | modelMatched);
		checkValue("playerLed", playerLed, modelPlayer);
		checkValue("gameOverLed", gameOverLed, modelGameOver);
		checkValue("scoreOneSeg", scoreOneSeg, memoryGamePkg::segmentsOf(modelScore[0]));
		checkValue("scoreTwoSeg", scoreTwoSeg, memoryGamePkg::segmentsOf(modelScore[1]));
	endtask

	// hides every face-up card that is not part of a found pair and hands the turn over.
	task automatic passTurn();
		modelShown = modelShown & modelMatched;
		modelFirstValid = 1'b0;
		modelWaiting = 1'b0;
		modelPlayer = !modelPlayer;
	endtask

	task automatic applySelect();
		logic [3:0] pos;
		pos = modelCursor;
		modelArmed = 1'b1;
		if (modelGameOver) begin
			return;
		end
		if (modelWaiting) begin
			passTurn();
		end else if (!modelShown[pos] && !modelMatched[pos]) begin
			modelShown[pos] = 1'b1;
			if (!modelFirstValid) begin
				modelFirst = pos;
				modelFirstValid = 1'b1;
			end else if ((pos % 8) == (modelFirst % 8)) begin
				modelMatched[pos] = 1'b1;
				modelMatched[modelFirst] = 1'b1;
				modelFirstValid = 1'b0;
				modelScore[modelPlayer] = modelScore[modelPlayer] + 4'd1;
				modelGameOver = (modelScore[0] + modelScore[1] == 8);
			end else begin
				modelFirstValid = 1'b0;
				modelWaiting = 1'b1;
			end
		end
	endtask

	task automatic pressButton(input logic isSelect);
		int cycle;
		for (cycle = 0; cycle < 28; cycle++) begin
			@(negedge clk50MHz);
			if (isSelect) begin
				btnSelect = (cycle < 14);
			end else begin
				btnMove = (cycle < 14);
			end
		end
		@(negedge clk50MHz);
	endtask

	task automatic doMove();
		pressButton(1'b0);
		modelCursor = modelCursor + 4'd1;
		checkBoard();
	endtask

	task automatic doSelect();
		pressButton(1'b1);
		applySelect();
		checkBoard();
		checkValue("secondsTens", secondsTens, memoryGamePkg::segmentsOf(4'd0));
		checkValue("secondsUnits", secondsUnits, memoryGamePkg::segmentsOf(4'd0));
	endtask

	task automatic moveTo(input logic [3:0] target);
		int n;
		for (n = 0; n < 16 && modelCursor != target; n++) begin
			doMove();
		end
	endtask

	task automatic idleTimeout();
		int waited;
		waited = 0;
		while (secondsUnits !== memoryGamePkg::segmentsOf(4'(TurnSeconds))
				&& waited < IdleLimit) begin
			@(negedge clk50MHz);
			waited++;
		end
		if (waited >= IdleLimit) begin
			$display("ERROR %0t: the seconds display never reached the turn limit", $time);
			testErrors++;
		end
		// the timeout pulse reaches the board one cycle after the display shows the limit.
		@(negedge clk50MHz);
		if (modelArmed && !modelGameOver) begin
			passTurn();
		end
		modelArmed = 1'b0;
		checkBoard();
	endtask

	task automatic finishTest(input string name);
		if (testErrors == 0) begin
			$display("%s: ok", name);
			passCount++;
		end else begin
			$display("%s: %0d errors", name, testErrors);
			failCount++;
		end
		testErrors = 0;
	endtask

	initial begin
		int n;
		int step;
		logic [31:0] rnd;
		logic [3:0] flipped;
		logic savedPlayer;
		seed = 32'h9067_1ec4;
		btnMove = 1'b0;
		btnSelect = 1'b0;
		modelCursor = '0;
		modelShown = '0;
		modelMatched = '0;
		modelFirst = '0;
		modelFirstValid = 1'b0;
		modelPlayer = 1'b0;
		modelScore[0] = '0;
		modelScore[1] = '0;
		modelWaiting = 1'b0;
		modelGameOver = 1'b0;
		modelArmed = 1'b1;
		testErrors = 0;
		passCount = 0;
		failCount = 0;
		for (n = 0; n < 10 && rstN !== 1'b1; n++) begin
			@(negedge clk50MHz);
		end
		if (rstN !== 1'b1) begin
			$display("ERROR %0t: reset was never released", $time);
			testErrors++;
		end
		@(negedge clk50MHz);
		checkBoard();
		finishTest("after reset");

		// the timer also runs out once after reset, with nothing flipped.
		idleTimeout();
		for (n = 0; n < 4; n++) begin
			rnd = nextRandom();
			repeat (1 + rnd[27:25]) doMove();
		end
		finishTest("move presses");

		step = 0;
		while (step < 30 && modelScore[0] + modelScore[1] < 6) begin
			rnd = nextRandom();
			if (modelFirstValid && rnd[31:30] == 2'b11) begin
				moveTo(modelFirst ^ 4'h8);
			end else begin
				moveTo(rnd[27:24]);
			end
			doSelect();
			step++;
		end
		finishTest("random play");

		idleTimeout();
		for (n = 0; n < 16 && (modelShown[modelCursor] || modelMatched[modelCursor]); n++) begin
			doMove();
		end
		flipped = modelCursor;
		doSelect();
		checkValue("shownMask[flipped]", shownMask[flipped], 1);
		savedPlayer = modelPlayer;
		idleTimeout();
		checkValue("secondsUnits", secondsUnits, memoryGamePkg::segmentsOf(4'(TurnSeconds)));
		checkValue("shownMask[flipped]", shownMask[flipped], 0);
		checkValue("playerLed", playerLed, !savedPlayer);
		finishTest("turn timeout");

		for (n = 0; n < 8; n++) begin
			if (!modelMatched[n]) begin
				moveTo(4'(n));
				doSelect();
				moveTo(4'(n + 8));
				doSelect();
			end
		end
		checkValue("gameOverLed", gameOverLed, 1);
		checkValue("scoreSum", digitOf(scoreOneSeg) + digitOf(scoreTwoSeg), 8);
		doSelect();
		doMove();
		doSelect();
		checkValue("shownMask", shownMask, 16'hffff);
		finishTest("play to the end");

		for (n = 0; n < 3; n++) begin
			idleTimeout();
			rnd = nextRandom();
			repeat (rnd[27:26]) doMove();
			doSelect();
		end
		finishTest("seconds restart");

		$display("%0d tests ok, %0d tests with errors", passCount, failCount);
		if (failCount == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== tests/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
	output logic clk50MHz,
	output logic rstN
);

	initial begin
		clk50MHz = 1'b0;
		forever begin
			#20 clk50MHz = ~clk50MHz;
		end
	end

	// reset covers three clock periods and is released on a falling edge.
	initial begin
		rstN = 1'b0;
		repeat (3) @(negedge clk50MHz);
		rstN = 1'b1;
	end

endmodule

// ==== verilog/memoryGameTop.sv ====
`timescale 1ns/1ps

module memoryGameTop #(
	parameter int DebounceCycles = 500000,
	parameter int CyclesPerSecond = 50000000,
	parameter int TurnSeconds = 10
) (
	input logic clk50MHz,
	input logic rstN,
	input logic btnMove,
	input logic btnSelect,
	output memoryGamePkg::cellPos_t cursor,
	output logic [15:0] shownMask,
	output logic playerLed,
	output logic gameOverLed,
	output logic [6:0] secondsTens,
	output logic [6:0] secondsUnits,
	output logic [6:0] scoreOneSeg,
	output logic [6:0] scoreTwoSeg
);

	logic movePress;
	logic selectPress;
	logic [4:0] seconds;
	logic timeout;
	memoryGamePkg::cell_t [memoryGamePkg::BoardCells-1:0] cells;
	memoryGamePkg::gameStatus_t status;

	buttonDebouncer #(
		.DebounceCycles(DebounceCycles)
	) i_moveDebouncer (
		.clk50MHz(clk50MHz),
		.rstN(rstN),
		.button(btnMove),
		.press(movePress)
	);

	buttonDebouncer #(
		.DebounceCycles(DebounceCycles)
	) i_selectDebouncer (
		.clk50MHz(clk50MHz),
		.rstN(rstN),
		.button(btnSelect),
		.press(selectPress)
	);

	cursorControl i_cursorControl (
		.clk50MHz(clk50MHz),
		.rstN(rstN),
		.movePress(movePress),
		.cursor(cursor)
	);

	turnTimer #(
		.CyclesPerSecond(CyclesPerSecond),
		.TurnSeconds(TurnSeconds)
	) i_turnTimer (
		.clk50MHz(clk50MHz),
		.rstN(rstN),
		.selectPress(selectPress),
		.seconds(seconds),
		.timeout(timeout)
	);

	gameBoard i_gameBoard (
		.clk50MHz(clk50MHz),
		.rstN(rstN),
		.selectPress(selectPress),
		.timeout(timeout),
		.cursor(cursor),
		.cells(cells),
		.status(status)
	);

	scoreDisplay i_scoreDisplay (
		.seconds(seconds),
		.status(status),
		.secondsTens(secondsTens),
		.secondsUnits(secondsUnits),
		.scoreOneSeg(scoreOneSeg),
		.scoreTwoSeg(scoreTwoSeg)
	);

	// a cell counts as visible while face up or once its pair is found.
	always_comb begin
		for (int i = 0; i < memoryGamePkg::BoardCells; i++) begin
			shownMask[i] = cells[i].shown | cells[i].matched;
		end
	end

	assign playerLed = status.player;
	assign gameOverLed = status.gameOver;

endmodule

// ==== verilog/scoreDisplay.sv ====
`timescale 1ns/1ps

module scoreDisplay (
	input logic [4:0] seconds,
	input memoryGamePkg::gameStatus_t status,
	output logic [6:0] secondsTens,
	output logic [6:0] secondsUnits,
	output logic [6:0] scoreOneSeg,
	output logic [6:0] scoreTwoSeg
);

	logic [4:0] tensWide;
	logic [4:0] unitsWide;
	logic [3:0] tensDigit;
	logic [3:0] unitsDigit;

	// seconds stays below 32, so the tens digit never passes 3.
	always_comb begin
		tensWide = seconds / 5'd10;
		unitsWide = seconds % 5'd10;
		tensDigit = tensWide[3:0];
		unitsDigit = unitsWide[3:0];
	end

	assign secondsTens = memoryGamePkg::segmentsOf(tensDigit);
	assign secondsUnits = memoryGamePkg::segmentsOf(unitsDigit);

	// a score above 9 falls into the blank entry of the table.
	assign scoreOneSeg = memoryGamePkg::segmentsOf(status.scoreOne);
	assign scoreTwoSeg = memoryGamePkg::segmentsOf(status.scoreTwo);

endmodule

// ==== verilog/gameBoard.sv ====
`timescale 1ns/1ps

module gameBoard (
	input logic clk50MHz,
	input logic rstN,
	input logic selectPress,
	input logic timeout,
	input memoryGamePkg::cellPos_t cursor,
	output memoryGamePkg::cell_t [memoryGamePkg::BoardCells-1:0] cells,
	output memoryGamePkg::gameStatus_t status
);

	memoryGamePkg::cellPos_t firstPos;
	logic firstValid;
	logic [4:0] scoreSum;
	logic [4:0] openCount;
	logic allMatched;
	logic cursorFree;
	logic pairFound;

	always_comb begin
		scoreSum = 5'(status.scoreOne) + 5'(status.scoreTwo);
		openCount = '0;
		allMatched = 1'b1;
		for (int i = 0; i < memoryGamePkg::BoardCells; i++) begin
			if (cells[i].shown && !cells[i].matched) begin
				openCount = openCount + 5'd1;
			end
			allMatched = allMatched & cells[i].matched;
		end
	end

	assign cursorFree = !cells[cursor].shown && !cells[cursor].matched;
	assign pairFound = (cells[firstPos].value == cells[cursor].value);

	always_ff @(posedge clk50MHz or negedge rstN) begin
		if (!rstN) begin
			// fixed deal, cell i holds card i mod 8.
			for (int i = 0; i < memoryGamePkg::BoardCells; i++) begin
				cells[i].value <= memoryGamePkg::cardValue_t'(i % memoryGamePkg::CardKinds);
				cells[i].shown <= 1'b0;
				cells[i].matched <= 1'b0;
			end
			firstPos <= '0;
			firstValid <= 1'b0;
			status <= '0;
		end else if (selectPress && !status.gameOver) begin
			if (status.waiting) begin
				for (int i = 0; i < memoryGamePkg::BoardCells; i++) begin
					if (!cells[i].matched) begin
						cells[i].shown <= 1'b0;
					end
				end
				status.player <= ~status.player;
				status.waiting <= 1'b0;
			end else if (cursorFree) begin
				cells[cursor].shown <= 1'b1;
				if (!firstValid) begin
					firstPos <= cursor;
					firstValid <= 1'b1;
				end else if (pairFound) begin
					cells[cursor].matched <= 1'b1;
					cells[firstPos].matched <= 1'b1;
					firstValid <= 1'b0;
					if (status.player) begin
						status.scoreTwo <= status.scoreTwo + 1'b1;
					end else begin
						status.scoreOne <= status.scoreOne + 1'b1;
					end
					status.gameOver <= (scoreSum + 5'd1 == 5'(memoryGamePkg::CardKinds));
				end else begin
					firstValid <= 1'b0;
					status.waiting <= 1'b1;
				end
			end
		end else if (timeout && !status.gameOver) begin
			// the turn passes; any face-up card that is not part of a pair goes down.
			for (int i = 0; i < memoryGamePkg::BoardCells; i++) begin
				if (!cells[i].matched) begin
					cells[i].shown <= 1'b0;
				end
			end
			firstValid <= 1'b0;
			status.player <= ~status.player;
			status.waiting <= 1'b0;
		end
	end

	assert property (@(posedge clk50MHz) disable iff (!rstN)
		scoreSum <= 5'(memoryGamePkg::CardKinds));

	assert property (@(posedge clk50MHz) disable iff (!rstN)
		status.waiting |-> openCount == 5'd2);

	assert property (@(posedge clk50MHz) disable iff (!rstN)
		status.gameOver |-> allMatched);

endmodule

// ==== verilog/turnTimer.sv ====
`timescale 1ns/1ps

module turnTimer #(
	parameter int CyclesPerSecond = 50000000,
	parameter int TurnSeconds = 10
) (
	input logic clk50MHz,
	input logic rstN,
	input logic selectPress,
	output logic [4:0] seconds,
	output logic timeout
);

	localparam int PrescaleWidth = $clog2(CyclesPerSecond);

	logic [PrescaleWidth-1:0] prescaler;
	logic secondTick;
	logic saturated;

	assign secondTick = (prescaler == PrescaleWidth'(CyclesPerSecond - 1));
	assign saturated = (seconds == 5'(TurnSeconds));

	always_ff @(posedge clk50MHz or negedge rstN) begin
		if (!rstN) begin
			prescaler <= '0;
			seconds <= '0;
			timeout <= 1'b0;
		end else if (selectPress) begin
			prescaler <= '0;
			seconds <= '0;
			timeout <= 1'b0;
		end else if (!saturated) begin
			if (secondTick) begin
				prescaler <= '0;
				seconds <= seconds + 5'd1;
				timeout <= (seconds + 5'd1 == 5'(TurnSeconds));
			end else begin
				prescaler <= prescaler + 1'b1;
				timeout <= 1'b0;
			end
		end else begin
			// the count holds at the limit until the next select.
			timeout <= 1'b0;
		end
	end

	assert property (@(posedge clk50MHz) disable iff (!rstN) seconds <= 5'(TurnSeconds));

endmodule

// ==== verilog/cursorControl.sv ====
`timescale 1ns/1ps

module cursorControl (
	input logic clk50MHz,
	input logic rstN,
	input logic movePress,
	output memoryGamePkg::cellPos_t cursor
);

	// row-major walk, so the column advances first and carries into the row.
	always_ff @(posedge clk50MHz or negedge rstN) begin
		if (!rstN) begin
			cursor <= '0;
		end else if (movePress) begin
			// the index is four bits wide, so the last cell rolls over to cell 0.
			cursor <= cursor + 1'b1;
		end
	end

endmodule

// ==== verilog/buttonDebouncer.sv ====
`timescale 1ns/1ps

module buttonDebouncer #(
	parameter int DebounceCycles = 500000
) (
	input logic clk50MHz,
	input logic rstN,
	input logic button,
	output logic press
);

	localparam int CountWidth = $clog2(DebounceCycles + 1);

	logic syncMeta;
	logic syncLevel;
	logic cleanLevel;
	logic cleanLast;
	logic [CountWidth-1:0] stableCount;

	always_ff @(posedge clk50MHz or negedge rstN) begin
		if (!rstN) begin
			syncMeta <= 1'b0;
			syncLevel <= 1'b0;
			cleanLevel <= 1'b0;
			cleanLast <= 1'b0;
			stableCount <= '0;
			press <= 1'b0;
		end else begin
			syncMeta <= button;
			syncLevel <= syncMeta;
			// the count restarts whenever the synchronized level agrees with the clean one.
			if (syncLevel == cleanLevel) begin
				stableCount <= '0;
			end else if (stableCount == CountWidth'(DebounceCycles - 1)) begin
				stableCount <= '0;
				cleanLevel <= syncLevel;
			end else begin
				stableCount <= stableCount + 1'b1;
			end
			cleanLast <= cleanLevel;
			press <= cleanLevel & ~cleanLast;
		end
	end

	assert property (@(posedge clk50MHz) disable iff (!rstN) press |=> !press);

endmodule

// ==== verilog/memoryGamePkg.sv ====
package memoryGamePkg;

	localparam int BoardCells = 16;
	localparam int CardKinds = 8;

	// row sits in the upper two bits, column in the lower two.
	typedef logic [3:0] cellPos_t;
	typedef logic [2:0] cardValue_t;
	typedef logic [3:0] score_t;

	typedef struct packed {
		cardValue_t value;
		logic shown;
		logic matched;
	} cell_t;

	typedef struct packed {
		logic player;
		score_t scoreOne;
		score_t scoreTwo;
		logic gameOver;
		logic waiting;
	} gameStatus_t;

	// segment order is gfedcba, a lit segment is driven low.
	function automatic logic [6:0] segmentsOf(input logic [3:0] digit);
		case (digit)
			4'd0: return 7'b1000000;
			4'd1: return 7'b1111001;
			4'd2: return 7'b0100100;
			4'd3: return 7'b0110000;
			4'd4: return 7'b0011001;
			4'd5: return 7'b0010010;
			4'd6: return 7'b0000010;
			4'd7: return 7'b1111000;
			4'd8: return 7'b0000000;
			4'd9: return 7'b0010000;
			default: return 7'b1111111;
		endcase
	endfunction

endpackage
